/* Makefile */
TOP  := sd_card_emu_tb
SRCS := $(shell grep -v '^+' sd_card_emu.f)

obj_dir/V$(TOP): sd_card_emu.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sd_card_emu.f -o V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* bench/sd_card_emu_tb.sv */
// SD card emulator testbench
`timescale 1ns/1ps
`default_nettype none

module sd_card_emu_tb
    import sd_card_pkg::*;
();

    localparam logic [15:0] RCA       = 16'h0013;
    localparam logic [31:0] OCR       = 32'hC0FF_8000;   // Not busy, CCS, 2.7 to 3.6 V
    localparam int          NROWS     = 13;
    localparam int          RESP_WAIT = 64;

    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        resp_kind_e  kind;
        logic [31:0] payload;
        logic        bad_crc;
        logic        read;
    } row_t;

    logic        sdclk = 1'b0;
    logic        rstn_sdclk_p;
    logic        cmd_in;
    logic        cmd_out;
    logic        cmd_oe;
    logic        dat0_out;
    logic        dat0_oe;
    logic        rdreq;
    logic [39:0] rdaddr;
    logic [15:0] rddata = '0;

    row_t        rows [NROWS];
    read_req_t   blk_req;
    int          seed   = 70;
    int          cycle  = 0;
    int          limit  = 0;
    int          errors = 0;
    int          passed = 0;
    int          row_errors;
    int          end_cyc;

    sd_card_emu #(.RCA(RCA)) sd_card_emu_i (
        .sdclk        (sdclk),
        .rstn_sdclk_p (rstn_sdclk_p),
        .cmd_in       (cmd_in),
        .cmd_out      (cmd_out),
        .cmd_oe       (cmd_oe),
        .dat0_out     (dat0_out),
        .dat0_oe      (dat0_oe),
        .rdreq        (rdreq),
        .rdaddr       (rdaddr),
        .rddata       (rddata)
    );

    always #5 sdclk = ~sdclk;

    // ----------------------------------------------------------------------
    // RAM model and run limit
    // ----------------------------------------------------------------------

    function automatic logic [15:0] ram_word(input logic [39:0] a);
        return a[15:0] ^ a[31:16] ^ {8'h00, a[39:32]} ^ 16'hA5C3;   // Folds whole address
    endfunction

    always @(posedge sdclk) begin
        if (rdreq) begin
            rddata <= ram_word(rdaddr);
        end
    end

    always @(posedge sdclk) begin
        cycle <= cycle + 1;
        if (cycle > limit) begin
            $display("Timeout: the run went past %0d cycles", limit);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ----------------------------------------------------------------------
    // Reference models
    // ----------------------------------------------------------------------

    function automatic card_status_t status_of(input card_state_e st, input logic app,
                                               input logic ill);
        card_status_t s;
        s                 = '0;
        s.current_state   = st;
        s.ready_for_data  = 1'b1;
        s.app_cmd         = app;
        s.illegal_command = ill;
        return s;
    endfunction

    function automatic logic [31:0] r6_payload(input card_status_t s);
        logic [31:0] w;
        w = s;
        return {RCA, w[23:22], w[19], w[12:0]};    // Short status
    endfunction

    // Remainder of message times x^7 by 0x89
    function automatic logic [6:0] crc7_div(input logic [39:0] msg);
        logic [7:0] r;
        r = '0;
        for (int i = 46; i >= 0; i--) begin
            r = {r[6:0], (i >= 7) ? msg[i - 7] : 1'b0};
            if (r[7]) begin
                r = r ^ 8'h89;
            end
        end
        return r[6:0];
    endfunction

    function automatic logic [15:0] crc16_div(input logic [4095:0] msg);
        logic [16:0] r;
        r = '0;
        for (int i = 4111; i >= 0; i--) begin
            r = {r[15:0], (i >= 16) ? msg[i - 16] : 1'b0};
            if (r[16]) begin
                r = r ^ 17'h11021;
            end
        end
        return r[15:0];
    endfunction

    function automatic row_t make_row(input logic [5:0] index, input logic [31:0] arg,
                                      input resp_kind_e kind, input logic [31:0] payload,
                                      input logic bad_crc, input logic read);
        row_t r;
        r.index   = index;
        r.arg     = arg;
        r.kind    = kind;
        r.payload = payload;
        r.bad_crc = bad_crc;
        r.read    = read;
        return r;
    endfunction

    // ----------------------------------------------------------------------
    // Host side tasks
    // ----------------------------------------------------------------------

    task automatic report_mismatch(input string msg);
        $display("[FAIL] t=%0d ns: %s", $time, msg);
        errors++;
        row_errors++;
    endtask

    task automatic report_error(input string msg);
        $display("Error at %0d ns: %s", $time, msg);
        errors++;
        row_errors++;
    endtask

    task automatic send_cmd(input logic [5:0] index, input logic [31:0] arg,
                            input logic bad_crc);
        logic [47:0] bits;
        logic [6:0]  crc;
        crc  = '0;
        bits = {1'b0, 1'b1, index, arg, 8'h01};
        for (int i = 47; i >= 8; i--) begin
            crc = crc7_step(crc, bits[i]);
        end
        bits[7:1] = bad_crc ? (crc ^ 7'h01) : crc;
        for (int i = 47; i >= 0; i--) begin
            @(posedge sdclk);
            cmd_in <= bits[i];
        end
        @(negedge sdclk);
        end_cyc = cycle;                           // End bit on the line
    endtask

    task automatic capture_resp(output logic found, output int latency,
                                output logic [47:0] bits);
        found   = 1'b0;
        latency = 0;
        bits    = '1;
        for (int n = 0; n < RESP_WAIT && !found; n++) begin
            @(negedge sdclk);
            if (cmd_oe && !cmd_out) begin
                found   = 1'b1;
                latency = cycle - end_cyc;
            end
        end
        if (found) begin
            bits[47] = 1'b0;
            for (int i = 46; i >= 0; i--) begin
                @(negedge sdclk);
                bits[i] = cmd_out;
            end
        end
    endtask

    task automatic capture_block(output logic found, output int latency,
                                 output logic [4095:0] data, output logic [15:0] crc,
                                 output logic end_bit);
        found   = 1'b0;
        latency = 0;
        data    = '0;
        crc     = '0;
        end_bit = 1'b0;
        for (int n = 0; n < RESP_WAIT && !found; n++) begin
            @(negedge sdclk);
            if (dat0_oe && !dat0_out) begin
                found   = 1'b1;
                latency = cycle - end_cyc;
            end
        end
        if (found) begin
            for (int i = 4095; i >= 0; i--) begin
                @(negedge sdclk);
                data[i] = dat0_out;
            end
            for (int i = 15; i >= 0; i--) begin
                @(negedge sdclk);
                crc[i] = dat0_out;
            end
            @(negedge sdclk);
            end_bit = dat0_out && dat0_oe;
        end
    endtask

    // ----------------------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------------------

    task automatic check_resp(input resp_req_t exp, input logic found,
                              input logic [47:0] bits);
        resp_req_t got;
        got.kind    = found ? exp.kind : RESP_NONE;
        got.index   = bits[45:40];
        got.payload = bits[39:8];
        if (exp.kind == RESP_NONE) begin
            if (found) begin
                report_error("the card answered a command that needs no response");
            end
        end else if (!found) begin
            report_error("no response start bit within 64 cycles");
        end else begin
            if (got != exp) begin
                report_mismatch($sformatf("response index %0d payload %08h, expected %0d %08h",
                                          got.index, got.payload, exp.index, exp.payload));
            end
            if (bits[46] || !bits[0]) begin
                report_mismatch("response transmit or end bit wrong");
            end
            if (exp.kind == RESP_R3 && bits[7:1] != 7'h7f) begin
                report_mismatch($sformatf("R3 CRC field %02h, expected 7f", bits[7:1]));
            end else if (exp.kind != RESP_R3 && bits[7:1] != crc7_div(bits[47:8])) begin
                report_mismatch($sformatf("response CRC7 %02h, expected %02h",
                                          bits[7:1], crc7_div(bits[47:8])));
            end
        end
    endtask

    task automatic check_status(input card_status_t exp, input card_status_t got);
        if (got != exp) begin
            report_mismatch($sformatf("status %08h state %s illegal %0b, expected %08h %s %0b",
                                      got, got.current_state.name(), got.illegal_command,
                                      exp, exp.current_state.name(), exp.illegal_command));
        end
    endtask

    task automatic check_latency(input string what, input int exp, input int got);
        if (got != exp) begin
            report_mismatch($sformatf("%s %0d cycles after end bit, expected %0d",
                                      what, got, exp));
        end
    endtask

    task automatic check_block(input read_req_t req, input logic [4095:0] data,
                               input logic [15:0] crc, input logic end_bit);
        logic [4095:0] exp;
        logic [15:0]   w;
        int            bad;
        bad = -1;
        for (int k = 0; k < 256; k++) begin
            w = ram_word({req.sector, 8'(k)});
            exp[4095 - 16*k -: 16] = {w[7:0], w[15:8]};    // Low byte first
        end
        for (int b = 0; b < 512 && bad < 0; b++) begin
            if (data[4095 - 8*b -: 8] != exp[4095 - 8*b -: 8]) begin
                bad = b;
            end
        end
        if (bad >= 0) begin
            report_mismatch($sformatf("block byte %0d is %02h, expected %02h", bad,
                                      data[4095 - 8*bad -: 8], exp[4095 - 8*bad -: 8]));
        end
        if (crc != crc16_div(exp)) begin
            report_mismatch($sformatf("block CRC16 %04h, expected %04h", crc, crc16_div(exp)));
        end
        if (!end_bit) begin
            report_mismatch("block end bit missing");
        end
    endtask

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------

    initial begin
        logic [47:0]   resp_bits;
        logic          resp_found;
        int            resp_lat;
        logic [4095:0] blk_data;
        logic [15:0]   blk_crc;
        logic          blk_end;
        logic          blk_found;
        int            blk_lat;
        resp_req_t     exp_resp;

        rstn_sdclk_p   <= 1'b0;
        cmd_in         <= 1'b1;
        blk_req.sector = $random(seed);

        rows[0]  = make_row(CMD_GO_IDLE, 32'h0, RESP_NONE, '0, 1'b0, 1'b0);
        rows[1]  = make_row(CMD_IF_COND, 32'h1AA, RESP_R7, 32'h1AA, 1'b0, 1'b0);
        rows[2]  = make_row(CMD_APP_CMD, 32'h0, RESP_R1, status_of(ST_IDLE, 1'b1, 1'b0),
                            1'b0, 1'b0);
        rows[3]  = make_row(ACMD_OP_COND, 32'h40FF_8000, RESP_R3, OCR, 1'b0, 1'b0);
        rows[4]  = make_row(CMD_SEND_RCA, 32'h0, RESP_R6,
                            r6_payload(status_of(ST_IDLE, 1'b0, 1'b0)), 1'b0, 1'b0);
        rows[5]  = make_row(CMD_SELECT, {RCA, 16'h0}, RESP_R1,
                            status_of(ST_STBY, 1'b0, 1'b0), 1'b0, 1'b0);
        rows[6]  = make_row(CMD_SEND_STATUS, {RCA, 16'h0}, RESP_R1,
                            status_of(ST_TRAN, 1'b0, 1'b0), 1'b0, 1'b0);
        rows[7]  = make_row(CMD_SEND_STATUS, {RCA, 16'h0}, RESP_NONE, '0, 1'b1, 1'b0);
        rows[8]  = rows[6];
        rows[9]  = make_row(6'd5, 32'h0, RESP_NONE, '0, 1'b0, 1'b0);
        rows[10] = make_row(CMD_SEND_STATUS, {RCA, 16'h0}, RESP_R1,
                            status_of(ST_TRAN, 1'b0, 1'b1), 1'b0, 1'b0);
        rows[11] = make_row(CMD_READ_SINGLE, blk_req.sector, RESP_R1,
                            status_of(ST_TRAN, 1'b0, 1'b0), 1'b0, 1'b1);
        rows[12] = rows[6];

        limit = 100;
        for (int r = 0; r < NROWS; r++) begin
            limit += 200 + (rows[r].read ? 4200 : 0);
        end

        repeat (10) @(posedge sdclk);
        rstn_sdclk_p <= 1'b1;
        repeat (4) @(posedge sdclk);

        for (int r = 0; r < NROWS; r++) begin
            row_errors = 0;
            blk_found  = 1'b0;
            send_cmd(rows[r].index, rows[r].arg, rows[r].bad_crc);
            if (rows[r].read) begin
                fork
                    capture_resp(resp_found, resp_lat, resp_bits);
                    capture_block(blk_found, blk_lat, blk_data, blk_crc, blk_end);
                join
            end else begin
                capture_resp(resp_found, resp_lat, resp_bits);
            end

            exp_resp.kind    = rows[r].kind;
            exp_resp.index   = (rows[r].kind == RESP_R3) ? 6'h3f : rows[r].index;
            exp_resp.payload = rows[r].payload;
            check_resp(exp_resp, resp_found, resp_bits);
            if (resp_found) begin
                check_latency("response start", 6, resp_lat);
            end
            if (resp_found && rows[r].index == CMD_SEND_STATUS) begin
                check_status(card_status_t'(rows[r].payload), card_status_t'(resp_bits[39:8]));
            end
            if (rows[r].read && !blk_found) begin
                report_error("no data start bit on DAT0 after the read command");
            end else if (rows[r].read) begin
                check_latency("data start", 19, blk_lat);
                check_block(blk_req, blk_data, blk_crc, blk_end);
            end

            if (row_errors == 0) begin
                passed++;
                $display("Test %0d CMD%0d: ok", r, rows[r].index);
            end else begin
                $display("Test %0d CMD%0d: %0d errors", r, rows[r].index, row_errors);
            end
            repeat (8) @(posedge sdclk);
        end

        $display("Tests %0d, passed %0d, failed %0d, errors %0d",
                 NROWS, passed, NROWS - passed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sd_card_emu.f */
verilog/sd_card_pkg.sv
verilog/sd_cmd_receiver.sv
verilog/sd_card_controller.sv
verilog/sd_resp_transmitter.sv
verilog/sd_block_reader.sv
verilog/sd_card_emu.sv
bench/sd_card_emu_tb.sv

/* verilog/sd_block_reader.sv */
// SD single block reader
`timescale 1ns/1ps
`default_nettype none

module sd_block_reader
    import sd_card_pkg::*;
(
    input  logic        sdclk,
    input  logic        rstn_sdclk_p,
    input  logic        read_valid,
    input  read_req_t   read,
    input  logic [15:0] rddata,
    output logic        rdreq,
    output logic [39:0] rdaddr,
    output logic        dat0_out,
    output logic        dat0_oe,
    output logic        read_busy
);

    localparam logic [12:0] START_POS = 13'(DATA_WAIT_BITS);
    localparam logic [12:0] DATA_POS  = START_POS + 13'd1;
    localparam logic [12:0] CRC_POS   = DATA_POS + 13'(BLOCK_BITS);
    localparam logic [12:0] END_POS   = CRC_POS + 13'd16;

    logic [12:0] cnt;
    logic [12:0] pos;
    logic [12:0] fetch;
    logic [3:0]  dbit;
    logic [15:0] word_bits;
    logic [15:0] shreg;
    logic [15:0] crc;
    logic [31:0] sector;
    logic        bit_out;
    logic        in_data;

    assign pos     = cnt + 13'd1;                     // Bit position driven next
    assign fetch   = pos - (DATA_POS - 13'd2);       // Request two bits ahead
    assign dbit    = pos[3:0] - DATA_POS[3:0];
    assign in_data = (pos >= DATA_POS) && (pos < CRC_POS);

    // Low byte goes first, each byte MSB first
    assign word_bits = {rddata[7:0], rddata[15:8]};
    assign bit_out   = (dbit == 4'd0) ? word_bits[15] : shreg[15];

    always_ff @(posedge sdclk or negedge rstn_sdclk_p) begin
        if (!rstn_sdclk_p) begin
            read_busy <= 1'b0;
            dat0_oe   <= 1'b0;
            dat0_out  <= 1'b1;
            rdreq     <= 1'b0;
            rdaddr    <= '0;
            cnt       <= '0;
            crc       <= '0;
        end else begin
            rdreq <= 1'b0;
            if (!read_busy) begin
                dat0_oe  <= 1'b0;
                dat0_out <= 1'b1;
                if (read_valid) begin
                    read_busy <= 1'b1;
                    dat0_oe   <= 1'b1;
                    cnt       <= '0;
                end
            end else begin
                cnt    <= pos;
                rdreq  <= (fetch[3:0] == 4'd0) && (fetch < 13'(BLOCK_BITS));
                rdaddr <= {sector, fetch[11:4]};
                if (pos < START_POS) begin
                    dat0_out <= 1'b1;
                end else if (pos == START_POS) begin
                    dat0_out <= 1'b0;
                    crc      <= '0;
                end else if (in_data) begin
                    dat0_out <= bit_out;
                    crc      <= crc16_step(crc, bit_out);
                end else if (pos < END_POS) begin
                    dat0_out <= crc[15];
                    crc      <= {crc[14:0], 1'b0};
                end else if (pos == END_POS) begin
                    dat0_out <= 1'b1;               // End bit
                end else begin
                    dat0_oe   <= 1'b0;
                    read_busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge sdclk) begin
        if (read_valid && !read_busy) begin
            sector <= read.sector;
        end
        if (read_busy && in_data) begin
            shreg <= (dbit == 4'd0) ? {word_bits[14:0], 1'b0} : {shreg[14:0], 1'b0};
        end
    end

    a_rdreq_in_read: assert property (@(posedge sdclk) disable iff (!rstn_sdclk_p)
        rdreq |-> read_busy);

endmodule

`default_nettype wire

/* verilog/sd_card_controller.sv */
// SD card state and command decode
`timescale 1ns/1ps
`default_nettype none

module sd_card_controller
    import sd_card_pkg::*;
#(
    parameter logic [15:0] RCA = 16'h0013
) (
    input  logic       sdclk,
    input  logic       rstn_sdclk_p,
    input  logic       frame_valid,
    input  cmd_frame_t frame,
    input  logic       read_busy,
    output logic       resp_valid,
    output resp_req_t  resp,
    output logic       read_valid,
    output read_req_t  read
);

    card_status_t status;
    card_status_t status_n;
    logic         last_acmd;
    logic         last_acmd_n;
    resp_req_t    resp_n;
    logic         read_valid_n;
    logic [31:0]  status_word;
    logic         rca_match;

    assign rca_match = (frame.arg[31:16] == RCA);

    // ----------------------------------------------------------------------
    // Next status and response
    // ----------------------------------------------------------------------

    always_comb begin
        status_n       = status;
        last_acmd_n    = last_acmd;
        resp_n.kind    = RESP_NONE;
        resp_n.index   = frame.index;
        resp_n.payload = '0;
        read_valid_n   = 1'b0;
        status_word    = '0;

        if (read_busy) begin
            status_n.current_state = ST_DATA;
        end else if (status.current_state == ST_DATA) begin
            status_n.current_state = ST_TRAN;     // Block done
        end

        if (frame_valid) begin
            last_acmd_n      = 1'b0;
            status_n.app_cmd = 1'b0;
            case (frame.index)
                CMD_GO_IDLE: begin
                    status_n                = '0;
                    status_n.ready_for_data = 1'b1;
                end
                CMD_SEND_RCA: begin
                    status_word              = status_n;
                    resp_n.kind              = RESP_R6;
                    resp_n.payload           = {RCA, status_word[23:22], status_word[19],
                                                status_word[12:0]};
                    status_n.current_state   = ST_STBY;
                    status_n.illegal_command = 1'b0;
                end
                CMD_SELECT: begin
                    if (rca_match) begin
                        resp_n.kind            = RESP_R1;
                        resp_n.payload         = status_n;
                        status_n.current_state = ST_TRAN;
                    end else begin
                        status_n.current_state = ST_STBY;   // Deselect, silent
                    end
                    status_n.illegal_command = 1'b0;
                end
                CMD_IF_COND: begin
                    resp_n.kind              = RESP_R7;
                    resp_n.payload           = {24'd1, frame.arg[7:0]};
                    status_n.illegal_command = 1'b0;
                end
                CMD_SEND_STATUS: begin
                    if (rca_match) begin
                        resp_n.kind              = RESP_R1;
                        resp_n.payload           = status_n;
                        status_n.illegal_command = 1'b0;
                    end
                end
                CMD_READ_SINGLE: begin
                    if (status_n.current_state == ST_TRAN) begin
                        resp_n.kind              = RESP_R1;
                        resp_n.payload           = status_n;
                        read_valid_n             = 1'b1;
                        status_n.illegal_command = 1'b0;
                    end
                end
                CMD_APP_CMD: begin
                    if (frame.arg[31:16] == 16'd0 || rca_match) begin
                        last_acmd_n              = 1'b1;
                        status_n.app_cmd         = 1'b1;
                        resp_n.kind              = RESP_R1;
                        resp_n.payload           = status_n;
                        status_n.illegal_command = 1'b0;
                    end
                end
                ACMD_OP_COND: begin
                    if (last_acmd) begin
                        status_n.app_cmd         = 1'b1;
                        resp_n.kind              = RESP_R3;
                        resp_n.payload           = OCR_VALUE;
                        status_n.illegal_command = 1'b0;
                    end
                end
                default: begin
                    status_n.illegal_command = 1'b1;
                end
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Registers
    // ----------------------------------------------------------------------

    always_ff @(posedge sdclk or negedge rstn_sdclk_p) begin
        if (!rstn_sdclk_p) begin
            status     <= '0;
            last_acmd  <= 1'b0;
            resp_valid <= 1'b0;
            read_valid <= 1'b0;
        end else begin
            status     <= status_n;
            last_acmd  <= last_acmd_n;
            resp_valid <= (resp_n.kind != RESP_NONE);
            read_valid <= read_valid_n;
        end
    end

    always_ff @(posedge sdclk) begin
        resp        <= resp_n;
        read.sector <= frame.arg;    // SDHC argument is the block number
    end

endmodule

`default_nettype wire

/* verilog/sd_card_emu.sv */
// Read-only SDHC card emulator
`timescale 1ns/1ps
`default_nettype none

module sd_card_emu
    import sd_card_pkg::*;
#(
    parameter logic [15:0] RCA = 16'h0013
) (
    input  logic        sdclk,
    input  logic        rstn_sdclk_p,
    input  logic        cmd_in,
    output logic        cmd_out,
    output logic        cmd_oe,
    output logic        dat0_out,
    output logic        dat0_oe,
    output logic        rdreq,
    output logic [39:0] rdaddr,
    input  logic [15:0] rddata
);

    logic       frame_valid;
    cmd_frame_t frame;
    logic       resp_valid;
    resp_req_t  resp;
    logic       resp_busy;
    logic       read_valid;
    read_req_t  read;
    logic       read_busy;

    sd_cmd_receiver u_receiver (
        .sdclk        (sdclk),
        .rstn_sdclk_p (rstn_sdclk_p),
        .cmd_in       (cmd_in),
        .resp_busy    (resp_busy),
        .frame_valid  (frame_valid),
        .frame        (frame)
    );

    sd_card_controller #(
        .RCA (RCA)
    ) u_controller (
        .sdclk        (sdclk),
        .rstn_sdclk_p (rstn_sdclk_p),
        .frame_valid  (frame_valid),
        .frame        (frame),
        .read_busy    (read_busy),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .read_valid   (read_valid),
        .read         (read)
    );

    sd_resp_transmitter u_transmitter (
        .sdclk        (sdclk),
        .rstn_sdclk_p (rstn_sdclk_p),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .cmd_out      (cmd_out),
        .cmd_oe       (cmd_oe),
        .resp_busy    (resp_busy)
    );

    sd_block_reader u_reader (
        .sdclk        (sdclk),
        .rstn_sdclk_p (rstn_sdclk_p),
        .read_valid   (read_valid),
        .read         (read),
        .rddata       (rddata),
        .rdreq        (rdreq),
        .rdaddr       (rdaddr),
        .dat0_out     (dat0_out),
        .dat0_oe      (dat0_oe),
        .read_busy    (read_busy)
    );

endmodule

`default_nettype wire

/* verilog/sd_card_pkg.sv */
// SD card emulator definitions
`default_nettype none

package sd_card_pkg;

    // ----------------------------------------------------------------------
    // Encodings
    // ----------------------------------------------------------------------

    typedef enum logic [3:0] {
        ST_IDLE  = 4'd0,
        ST_READY = 4'd1,
        ST_IDENT = 4'd2,
        ST_STBY  = 4'd3,
        ST_TRAN  = 4'd4,
        ST_DATA  = 4'd5
    } card_state_e;

    typedef enum logic [5:0] {
        CMD_GO_IDLE     = 6'd0,
        CMD_SEND_RCA    = 6'd3,
        CMD_SELECT      = 6'd7,
        CMD_IF_COND     = 6'd8,
        CMD_SEND_STATUS = 6'd13,
        CMD_READ_SINGLE = 6'd17,
        ACMD_OP_COND    = 6'd41,
        CMD_APP_CMD     = 6'd55
    } cmd_index_e;

    typedef enum logic [2:0] {
        RESP_NONE,
        RESP_R1,
        RESP_R3,
        RESP_R6,
        RESP_R7
    } resp_kind_e;

    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
    } cmd_frame_t;

    // R1 card status, bit 31 first
    typedef struct packed {
        logic        out_of_range;
        logic        address_error;
        logic        block_len_error;
        logic [5:0]  erase_lock_crc;   // Erase, protect, lock and CRC errors
        logic        illegal_command;
        logic [8:0]  err_rsvd;         // ECC, CC, general error, erase flags
        card_state_e current_state;
        logic        ready_for_data;
        logic [1:0]  rsvd_mid;
        logic        app_cmd;
        logic [4:0]  rsvd_ake;
    } card_status_t;

    typedef struct packed {
        resp_kind_e  kind;
        logic [5:0]  index;
        logic [31:0] payload;
    } resp_req_t;

    typedef struct packed {
        logic [31:0] sector;
    } read_req_t;

    // ----------------------------------------------------------------------
    // Card constants and timing
    // ----------------------------------------------------------------------

    // Not busy, SDHC, 2.7 to 3.6 V
    localparam logic [31:0] OCR_VALUE = {1'b1, 1'b1, 6'b0, 9'h1ff, 7'b0, 1'b0, 7'b0};

    localparam int RESP_WAIT_BITS = 4;
    localparam int DATA_WAIT_BITS = 16;
    localparam int BLOCK_BITS     = 4096;

    // x^7 + x^3 + 1
    function automatic logic [6:0] crc7_step(input logic [6:0] crc, input logic din);
        logic fb;
        fb = crc[6] ^ din;
        return {crc[5:0], fb} ^ {3'b0, fb, 3'b0};
    endfunction

    // x^16 + x^12 + x^5 + 1
    function automatic logic [15:0] crc16_step(input logic [15:0] crc, input logic din);
        logic fb;
        fb = crc[15] ^ din;
        return {crc[14:0], fb} ^ {3'b0, fb, 6'b0, fb, 5'b0};
    endfunction

endpackage

`default_nettype wire

/* verilog/sd_cmd_receiver.sv */
// SD command line receiver
`timescale 1ns/1ps
`default_nettype none

module sd_cmd_receiver
    import sd_card_pkg::*;
(
    input  logic       sdclk,
    input  logic       rstn_sdclk_p,
    input  logic       cmd_in,
    input  logic       resp_busy,
    output logic       frame_valid,
    output cmd_frame_t frame
);

    logic [47:0] shreg;
    logic [47:0] shreg_next;
    logic [6:0]  crc_calc;
    logic        framed;

    assign shreg_next = {shreg[46:0], cmd_in};

    // Start 0, host transmit bit 1, end bit 1
    assign framed = (shreg_next[47:46] == 2'b01) && shreg_next[0];

    always_comb begin
        crc_calc = '0;
        for (int i = 47; i >= 8; i--) begin
            crc_calc = crc7_step(crc_calc, shreg_next[i]);
        end
    end

    always_ff @(posedge sdclk or negedge rstn_sdclk_p) begin
        if (!rstn_sdclk_p) begin
            shreg       <= '1;
            frame_valid <= 1'b0;
        end else begin
            frame_valid <= 1'b0;
            if (!resp_busy) begin
                if (framed) begin
                    shreg       <= '1;                            // Drop frame on bad CRC
                    frame_valid <= (crc_calc == shreg_next[7:1]);
                end else begin
                    shreg <= shreg_next;
                end
            end
        end
    end

    always_ff @(posedge sdclk) begin
        if (framed) begin
            frame.index <= shreg_next[45:40];
            frame.arg   <= shreg_next[39:8];
        end
    end

    // Line is ignored for the whole response, so no frame can complete then
    a_no_frame_in_resp: assert property (@(posedge sdclk) disable iff (!rstn_sdclk_p)
        frame_valid |-> !resp_busy);

endmodule

`default_nettype wire

/* verilog/sd_resp_transmitter.sv */
// SD response transmitter
`timescale 1ns/1ps
`default_nettype none

module sd_resp_transmitter
    import sd_card_pkg::*;
(
    input  logic      sdclk,
    input  logic      rstn_sdclk_p,
    input  logic      resp_valid,
    input  resp_req_t resp,
    output logic      cmd_out,
    output logic      cmd_oe,
    output logic      resp_busy
);

    // Line stays released in the accept cycle, then ones until the start bit
    localparam logic [5:0] START_POS = 6'(RESP_WAIT_BITS - 2);
    localparam logic [5:0] CRC_POS   = START_POS + 6'd40;
    localparam logic [5:0] END_POS   = CRC_POS + 6'd7;

    logic [5:0]  pos;
    logic [39:0] shreg;
    logic [6:0]  crc;
    logic        dummy_crc;
    logic        accept;

    assign accept = resp_valid && !resp_busy;

    always_ff @(posedge sdclk or negedge rstn_sdclk_p) begin
        if (!rstn_sdclk_p) begin
            resp_busy <= 1'b0;
            cmd_oe    <= 1'b0;
            cmd_out   <= 1'b1;
            pos       <= '0;
            crc       <= '0;
        end else if (!resp_busy) begin
            cmd_oe  <= 1'b0;
            cmd_out <= 1'b1;
            if (resp_valid) begin
                resp_busy <= 1'b1;
                pos       <= '0;
                crc       <= '0;
            end
        end else begin
            pos    <= pos + 6'd1;
            cmd_oe <= 1'b1;
            if (pos < START_POS) begin
                cmd_out <= 1'b1;
            end else if (pos < CRC_POS) begin
                cmd_out <= shreg[39];
                crc     <= crc7_step(crc, shreg[39]);
            end else if (pos < END_POS) begin
                cmd_out <= crc[6] | dummy_crc;
                crc     <= {crc[5:0], 1'b0};
            end else if (pos == END_POS) begin
                cmd_out <= 1'b1;                // End bit
            end else begin
                cmd_oe    <= 1'b0;
                resp_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge sdclk) begin
        if (accept) begin
            shreg     <= {2'b00, (resp.kind == RESP_R3) ? 6'h3f : resp.index, resp.payload};
            dummy_crc <= (resp.kind == RESP_R3);   // R3 has no CRC
        end else if (resp_busy && pos >= START_POS && pos < CRC_POS) begin
            shreg <= {shreg[38:0], 1'b0};
        end
    end

    a_no_overlap: assert property (@(posedge sdclk) disable iff (!rstn_sdclk_p)
        resp_valid |-> !resp_busy);

endmodule

`default_nettype wire
